//--- hdl/rvCorePkg.sv
// ####################################################################
// rv64 core package with widths, opcodes, control enums and the
// decoded-control and commit-record structs
// ####################################################################
`default_nettype none

package rvCorePkg;

  localparam int XLEN = 64;                    // data width
  localparam int DMEM_BYTES = 2048;            // data memory size, wraps
  localparam int DMEM_AW = $clog2(DMEM_BYTES); // byte index width
  localparam logic [XLEN-1:0] RESET_PC = '0;   // first fetch address
  localparam logic [31:0] EBREAK_INSTR = 32'h0010_0073;

  // major opcodes, instr[6:0]
  typedef enum logic [6:0] {
    opcLui    = 7'b0110111,
    opcAuipc  = 7'b0010111,
    opcJal    = 7'b1101111,
    opcJalr   = 7'b1100111,
    opcOpImm  = 7'b0010011,
    opcOp     = 7'b0110011,
    opcBranch = 7'b1100011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcSystem = 7'b1110011
  } opcode_t;

  typedef enum logic [3:0] {
    aluAdd, aluSub, aluSll, aluSlt, aluSltu, aluXor,
    aluSrl, aluSra, aluOr, aluAnd, aluCopyB, aluMul
  } aluOp_t;

  typedef enum logic [2:0] {extI, extU, extS, extB, extJ, extR} extOp_t; // extR: no imm

  typedef enum logic {srcPc, srcRs1} srcA_t;
  typedef enum logic [1:0] {srcRs2, srcImm, srcFour} srcB_t;

  typedef enum logic [3:0] {
    brNone, brJal, brJalr, brEq, brNe, brLt, brGe, brLtu, brGeu
  } branchOp_t;

  // {unsigned, size}, same layout as load funct3
  typedef enum logic [2:0] {
    memByte  = 3'b000, memHalf  = 3'b001, memWord  = 3'b010, memDouble  = 3'b011,
    memByteU = 3'b100, memHalfU = 3'b101, memWordU = 3'b110, memDoubleU = 3'b111
  } memOp_t;

  typedef enum logic [1:0] {haltNone, haltEbreak, haltIllegal} haltCause_t;

  typedef struct packed {
    srcA_t      srcA;
    srcB_t      srcB;
    aluOp_t     aluOp;
    extOp_t     extOp;
    branchOp_t  branchOp;
    memOp_t     memOp;
    logic       memRead;
    logic       memWrite;
    logic       memToReg;  // writeback from load data
    logic       regWrite;
    logic       halt;
    haltCause_t haltCause;
  } ctrl_t;

  // one record per retired instruction
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [31:0]     instr;
    logic [4:0]      rdAddr;
    logic            rdWrite;
    logic [XLEN-1:0] rdData;
    logic [XLEN-1:0] nextPc;
    logic            memWrite;
    logic [XLEN-1:0] memAddr;
    logic [XLEN-1:0] memData;
  } retire_t;

endpackage

`default_nettype wire

//--- hdl/rvDecoder.sv
// ####################################################################
// rv64 instruction decoder, builds the control fields and the
// sign-extended immediate, flags ebreak and illegal encodings
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvDecoder (
  input  logic [31:0]      instr,
  output rvCorePkg::ctrl_t ctrl,
  output logic [63:0]      imm
);
  import rvCorePkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       illegal;  // encoding outside the supported set

  assign opcode = opcode_t'(instr[6:0]);
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  // shared funct3 map for OP and OP-IMM, alt picks sub/sra
  function automatic aluOp_t f3ToAlu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? aluSub : aluAdd;
      3'b001:  return aluSll;
      3'b010:  return aluSlt;
      3'b011:  return aluSltu;
      3'b100:  return aluXor;
      3'b101:  return alt ? aluSra : aluSrl;
      3'b110:  return aluOr;
      default: return aluAnd;
    endcase
  endfunction

  always_comb begin
    ctrl.srcA      = srcRs1;
    ctrl.srcB      = srcRs2;
    ctrl.aluOp     = aluAdd;
    ctrl.extOp     = extR;
    ctrl.branchOp  = brNone;
    ctrl.memOp     = memOp_t'(funct3);  // only meaningful for loads/stores
    ctrl.memRead   = 1'b0;
    ctrl.memWrite  = 1'b0;
    ctrl.memToReg  = 1'b0;
    ctrl.regWrite  = 1'b0;
    ctrl.halt      = 1'b0;
    ctrl.haltCause = haltNone;
    illegal        = 1'b0;
    case (opcode)
      opcLui: begin
        ctrl.srcB = srcImm; ctrl.extOp = extU; ctrl.aluOp = aluCopyB; ctrl.regWrite = 1'b1;
      end
      opcAuipc: begin
        ctrl.srcA = srcPc; ctrl.srcB = srcImm; ctrl.extOp = extU; ctrl.regWrite = 1'b1;
      end
      opcJal: begin  // alu gives the link pc+4
        ctrl.srcA = srcPc; ctrl.srcB = srcFour; ctrl.extOp = extJ;
        ctrl.branchOp = brJal; ctrl.regWrite = 1'b1;
      end
      opcJalr: begin
        ctrl.srcA = srcPc; ctrl.srcB = srcFour; ctrl.extOp = extI;
        ctrl.branchOp = brJalr; ctrl.regWrite = 1'b1;
        illegal = (funct3 != 3'b000);
      end
      opcOpImm: begin
        ctrl.srcB = srcImm; ctrl.extOp = extI; ctrl.regWrite = 1'b1;
        ctrl.aluOp = f3ToAlu(funct3, (funct3 == 3'b101) && instr[30]);  // addi never subs
        if (funct3 == 3'b001) illegal = (instr[31:26] != 6'b0);
        if (funct3 == 3'b101) illegal = ({instr[31], instr[29:26]} != 5'b0);
      end
      opcOp: begin
        ctrl.regWrite = 1'b1;
        case (funct7)
          7'b0000000: ctrl.aluOp = f3ToAlu(funct3, 1'b0);
          7'b0100000: begin  // sub, sra only
            ctrl.aluOp = f3ToAlu(funct3, 1'b1);
            illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
          end
          7'b0000001: begin  // mul only, rest of M left out
            ctrl.aluOp = aluMul;
            illegal = (funct3 != 3'b000);
          end
          default: illegal = 1'b1;
        endcase
      end
      opcBranch: begin
        ctrl.extOp = extB;
        ctrl.aluOp = funct3[1] ? aluSltu : aluSlt;  // picks the sense of less
        case (funct3)
          3'b000:  ctrl.branchOp = brEq;
          3'b001:  ctrl.branchOp = brNe;
          3'b100:  ctrl.branchOp = brLt;
          3'b101:  ctrl.branchOp = brGe;
          3'b110:  ctrl.branchOp = brLtu;
          3'b111:  ctrl.branchOp = brGeu;
          default: illegal = 1'b1;
        endcase
      end
      opcLoad: begin
        ctrl.srcB = srcImm; ctrl.extOp = extI; ctrl.memRead = 1'b1;
        ctrl.memToReg = 1'b1; ctrl.regWrite = 1'b1;
        illegal = (funct3 == 3'b111);  // no ldu
      end
      opcStore: begin
        ctrl.srcB = srcImm; ctrl.extOp = extS; ctrl.memWrite = 1'b1;
        illegal = funct3[2];
      end
      opcSystem: begin
        if (instr == EBREAK_INSTR) begin
          ctrl.halt = 1'b1; ctrl.haltCause = haltEbreak;
        end else begin
          illegal = 1'b1;  // ecall, csr
        end
      end
      default: illegal = 1'b1;
    endcase
    if (illegal) begin  // squash all side effects
      ctrl.regWrite = 1'b0; ctrl.memWrite = 1'b0; ctrl.memRead = 1'b0;
      ctrl.memToReg = 1'b0; ctrl.branchOp = brNone;
      ctrl.halt = 1'b1; ctrl.haltCause = haltIllegal;
    end
  end

  always_comb begin
    case (ctrl.extOp)
      extI:    imm = {{52{instr[31]}}, instr[31:20]};
      extU:    imm = {{32{instr[31]}}, instr[31:12], 12'b0};
      extS:    imm = {{52{instr[31]}}, instr[31:25], instr[11:7]};
      extB:    imm = {{52{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      extJ:    imm = {{44{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
      default: imm = '0;  // R type
    endcase
  end

  // stores never write back, across every opcode path and the illegal squash
  always_comb begin
    assert (!(ctrl.memWrite && ctrl.regWrite))
      else $error("decoder: store with register writeback, instr %h", instr);
  end

endmodule

`default_nettype wire

//--- hdl/rvAlu.sv
// ####################################################################
// 64-bit ALU with operand select, also gives the compare flags
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvAlu (
  input  rvCorePkg::ctrl_t ctrl,
  input  logic [63:0]      pc,
  input  logic [63:0]      rs1,
  input  logic [63:0]      rs2,
  input  logic [63:0]      imm,
  output logic [63:0]      result,
  output logic             zero,
  output logic             less
);
  import rvCorePkg::*;

  logic [63:0] opA;
  logic [63:0] opB;
  logic [5:0]  shamt;  // rv64 shifts use 6 bits
  logic        lessS;
  logic        lessU;

  assign opA = (ctrl.srcA == srcPc) ? pc : rs1;

  always_comb begin
    case (ctrl.srcB)
      srcImm:  opB = imm;
      srcFour: opB = 64'd4;  // link value
      default: opB = rs2;
    endcase
  end

  assign shamt = opB[5:0];
  assign lessS = $signed(opA) < $signed(opB);
  assign lessU = opA < opB;

  always_comb begin
    case (ctrl.aluOp)
      aluSub:   result = opA - opB;
      aluSll:   result = opA << shamt;
      aluSlt:   result = {63'b0, lessS};
      aluSltu:  result = {63'b0, lessU};
      aluXor:   result = opA ^ opB;
      aluSrl:   result = opA >> shamt;
      aluSra:   result = $signed(opA) >>> shamt;
      aluOr:    result = opA | opB;
      aluAnd:   result = opA & opB;
      aluCopyB: result = opB;        // lui
      aluMul:   result = opA * opB;  // low 64 bits
      default:  result = opA + opB;
    endcase
  end

  // flags for the branch unit
  assign zero = (opA == opB);
  assign less = (ctrl.aluOp == aluSltu) ? lessU : lessS;

endmodule

`default_nettype wire

//--- hdl/rvRegFile.sv
// ####################################################################
// 32 x 64 register file, x0 reads zero, 2 read 1 write
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvRegFile (
  input  logic        clk,
  input  logic        rst,
  input  logic [4:0]  rs1Addr,
  input  logic [4:0]  rs2Addr,
  output logic [63:0] rs1Data,
  output logic [63:0] rs2Data,
  input  logic        wrEn,
  input  logic [4:0]  wrAddr,
  input  logic [63:0] wrData
);

  logic [63:0] regs [32];

  assign rs1Data = regs[rs1Addr];  // async read
  assign rs2Data = regs[rs2Addr];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wrEn && (wrAddr != 5'd0)) begin  // x0 stays zero
      regs[wrAddr] <= wrData;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rvBranchUnit.sv
// ####################################################################
// branch decision and next-pc select for branches and jumps
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvBranchUnit (
  input  rvCorePkg::branchOp_t branchOp,
  input  logic                 zero,
  input  logic                 less,
  input  logic [63:0]          pc,
  input  logic [63:0]          imm,
  input  logic [63:0]          rs1,
  output logic [63:0]          nextPc
);
  import rvCorePkg::*;

  logic        taken;
  logic [63:0] jalrSum;

  always_comb begin
    case (branchOp)
      brEq, brJal: taken = (branchOp == brJal) || zero;
      brNe:        taken = !zero;
      brLt, brLtu: taken = less;   // signedness set by alu op
      brGe, brGeu: taken = !less;
      default:     taken = 1'b0;   // none, jalr
    endcase
  end

  assign jalrSum = rs1 + imm;

  always_comb begin
    if (branchOp == brJalr) nextPc = {jalrSum[63:1], 1'b0};
    else if (taken)         nextPc = pc + imm;
    else                    nextPc = pc + 64'd4;
  end

endmodule

`default_nettype wire

//--- hdl/rvDataMem.sv
// ####################################################################
// little-endian byte data memory, sized stores and extending loads
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvDataMem (
  input  logic              clk,
  input  logic [63:0]       addr,
  input  rvCorePkg::memOp_t memOp,
  input  logic              wrEn,
  input  logic [63:0]       wrData,
  output logic [63:0]       rdData
);
  import rvCorePkg::*;

  logic [7:0]         mem [DMEM_BYTES];
  logic [DMEM_AW-1:0] byteIdx [8];  // wrapped lane addresses
  logic [63:0]        raw;          // 8 bytes from addr up
  logic [3:0]         byteCount;

  assign byteCount = 4'd1 << memOp[1:0];  // 1, 2, 4 or 8

  always_comb begin
    for (int i = 0; i < 8; i++) begin
      byteIdx[i] = addr[DMEM_AW-1:0] + DMEM_AW'(i);
      raw[8*i +: 8] = mem[byteIdx[i]];
    end
  end

  always_ff @(posedge clk) begin
    if (wrEn) begin
      for (int i = 0; i < 8; i++) begin
        if (4'(i) < byteCount) mem[byteIdx[i]] <= wrData[8*i +: 8];  // low bytes only
      end
    end
  end

  always_comb begin
    case (memOp)
      memByte:  rdData = {{56{raw[7]}}, raw[7:0]};
      memHalf:  rdData = {{48{raw[15]}}, raw[15:0]};
      memWord:  rdData = {{32{raw[31]}}, raw[31:0]};
      memByteU: rdData = {56'b0, raw[7:0]};
      memHalfU: rdData = {48'b0, raw[15:0]};
      memWordU: rdData = {32'b0, raw[31:0]};
      default:  rdData = raw;  // ld
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/rvExecCore.sv
// ####################################################################
// rv64 execution core top, fetch handshake FSM, pc and datapath,
// one retire record per instruction
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvExecCore (
  input  logic                   clk,
  input  logic                   rst,
  output logic                   fetchReq,
  output logic [63:0]            fetchAddr,
  input  logic                   fetchAck,
  input  logic [31:0]            instr,
  output rvCorePkg::retire_t     retire,
  output logic                   halted,
  output rvCorePkg::haltCause_t  haltCause
);
  import rvCorePkg::*;

  typedef enum logic [1:0] {stRequest, stRelease, stExecute, stHalt} state_t;

  state_t      state;
  logic [31:0] instrQ;     // latched fetch word
  logic [63:0] pc;
  logic        fetchDone;  // ack seen on an open request
  logic        execute;
  ctrl_t       ctrl;
  logic [63:0] imm, rs1Data, rs2Data, aluResult, nextPc, loadData, wbData;
  logic        aluZero, aluLess;

  assign fetchAddr = pc;
  assign halted    = (state == stHalt);
  assign fetchDone = (state == stRequest) && fetchReq && fetchAck;
  assign execute   = (state == stExecute);

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= stRequest; fetchReq <= 1'b0; pc <= RESET_PC; haltCause <= haltNone;
    end else begin
      case (state)
        stRequest: begin
          if (!fetchReq) fetchReq <= 1'b1;  // one idle cycle after retire
          else if (fetchAck) begin
            fetchReq <= 1'b0;
            state    <= stRelease;
          end
        end
        stRelease: if (!fetchAck) state <= stExecute;  // wait for ack low
        stExecute: begin
          pc <= nextPc;
          if (ctrl.halt) begin
            state     <= stHalt;
            haltCause <= ctrl.haltCause;
          end else begin
            state <= stRequest;
          end
        end
        default: ;  // halted until reset
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (fetchDone) instrQ <= instr;
  end

  rvDecoder decoder (.instr(instrQ), .ctrl(ctrl), .imm(imm));

  rvRegFile regFile (
    .clk(clk), .rst(rst), .rs1Addr(instrQ[19:15]), .rs2Addr(instrQ[24:20]),
    .rs1Data(rs1Data), .rs2Data(rs2Data), .wrEn(execute && ctrl.regWrite),
    .wrAddr(instrQ[11:7]), .wrData(wbData)
  );

  rvAlu alu (
    .ctrl(ctrl), .pc(pc), .rs1(rs1Data), .rs2(rs2Data), .imm(imm),
    .result(aluResult), .zero(aluZero), .less(aluLess)
  );

  rvBranchUnit branchUnit (
    .branchOp(ctrl.branchOp), .zero(aluZero), .less(aluLess), .pc(pc), .imm(imm),
    .rs1(rs1Data), .nextPc(nextPc)
  );

  rvDataMem dataMem (
    .clk(clk), .addr(aluResult), .memOp(ctrl.memOp), .wrEn(execute && ctrl.memWrite),
    .wrData(rs2Data), .rdData(loadData)
  );

  always_comb begin
    if (ctrl.memToReg) wbData = loadData;
    else if ((ctrl.branchOp == brJal) || (ctrl.branchOp == brJalr)) wbData = pc + 64'd4;
    else wbData = aluResult;
  end

  // commit record, payload only loads in execute
  always_ff @(posedge clk) begin
    if (rst) begin
      retire.valid <= 1'b0;
    end else begin
      retire.valid <= execute;
      if (execute) begin
        retire.pc       <= pc;
        retire.instr    <= instrQ;
        retire.rdAddr   <= instrQ[11:7];
        retire.rdWrite  <= ctrl.regWrite;
        retire.rdData   <= wbData;
        retire.nextPc   <= nextPc;
        retire.memWrite <= ctrl.memWrite;
        retire.memAddr  <= aluResult;
        retire.memData  <= rs2Data;
      end
    end
  end

  // request address holds while the responder stalls
  fetchAddrStable: assert property (@(posedge clk) disable iff (rst)
    (fetchReq && !fetchAck) |=> (fetchAddr == $past(fetchAddr)))
    else $error("core: fetchAddr changed during an open request");

  // handshake plus execute keeps retires at least a cycle apart
  retireSinglePulse: assert property (@(posedge clk) disable iff (rst)
    retire.valid |=> !retire.valid)
    else $error("core: retire.valid high two cycles in a row");

endmodule

`default_nettype wire

//--- verification/rvCorePrograms.svh
// ####################################################################
// rv64 instruction encoders and the expected retire record layout
// ####################################################################
`ifndef RV_CORE_PROGRAMS_SVH
`define RV_CORE_PROGRAMS_SVH

// one expected commit, filled in by the test tasks
typedef struct packed {
  logic [63:0] pc;
  logic [31:0] instr;
  logic        rdWrite;
  logic [63:0] rdData;
  logic [63:0] nextPc;
  logic        memWrite;
  logic [63:0] memAddr;
  logic [63:0] memData;
  haltCause_t  cause;
} expect_t;

function automatic logic [31:0] encI(opcode_t op, int rd, int f3, int rs1, int imm);
  return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
endfunction

function automatic logic [31:0] encR(int f3, int f7, int rd, int rs1, int rs2);
  return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opcOp};
endfunction

function automatic logic [31:0] encS(int f3, int rs1, int rs2, int imm);
  return {imm[11:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:0], opcStore};
endfunction

function automatic logic [31:0] encB(int f3, int rs1, int rs2, int off);
  return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], opcBranch};
endfunction

function automatic logic [31:0] encU(opcode_t op, int rd, int imm);
  return {imm[19:0], rd[4:0], op};
endfunction

function automatic logic [31:0] encJ(int rd, int off);
  return {off[20], off[10:1], off[11], off[19:12], rd[4:0], opcJal};  // jal only
endfunction

`endif

//--- verification/rvCoreTb.sv
// ####################################################################
// testbench for the rv64 execution core, fetch responder, retire
// checks and directed program tests
// ####################################################################
`timescale 1ns/100ps
`default_nettype none

module rvCoreTb;
  import rvCorePkg::*;

  `include "rvCorePrograms.svh"

  localparam int TOTAL_INSTR = 70;                 // all tests together
  localparam int CYCLE_LIMIT = TOTAL_INSTR * 8 + 200;

  logic        clk, rst, fetchReq, fetchAck, halted;
  logic [63:0] fetchAddr;
  logic [31:0] instr;
  retire_t     retire;
  haltCause_t  haltCause;

  logic [31:0] prog [256];     // instruction words by pc[9:2]
  expect_t     expQ [$];
  logic [63:0] rngState = 64'd43;
  logic [63:0] lastNext = '0;  // address the next fetch must use
  int          handshakes = 0;
  int          retires = 0;
  int          cycles = 0;

  rvExecCore UUT (
    .clk(clk), .rst(rst), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .fetchAck(fetchAck), .instr(instr), .retire(retire), .halted(halted),
    .haltCause(haltCause)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [63:0] xorshift(input logic [63:0] s);
    logic [63:0] x;
    x = s ^ (s << 13);
    x = x ^ (x >> 7);
    return x ^ (x << 17);
  endfunction

  task automatic checkEq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h got %h", name, exp, act);
      $display("** FAIL **");
      $fatal(1);
    end
  endtask

  // four-phase responder with a random ack delay of 0..3 cycles
  initial begin
    int delay;
    rngState = xorshift(rngState);
    delay = int'(rngState[1:0]);
    forever begin
      @(posedge clk);
      #1;
      if (rst) begin
        fetchAck = 1'b0;
      end else if (fetchReq && !fetchAck) begin
        if (delay == 0) begin
          checkEq("fetchAddr", lastNext, fetchAddr);
          instr = prog[fetchAddr[9:2]];
          fetchAck = 1'b1;
          handshakes++;
          rngState = xorshift(rngState);
          delay = int'(rngState[1:0]);
        end else begin
          delay--;
        end
      end else if (fetchAck && !fetchReq) begin
        fetchAck = 1'b0;
      end
    end
  end

  // one retire per completed handshake
  initial begin
    forever begin
      @(posedge clk);
      #1;
      if (retire.valid) begin
        retires++;
        checkEq("retire count", 64'(handshakes), 64'(retires));
        lastNext = retire.nextPc;
      end
    end
  end

  initial begin
    while (cycles <= CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: the core stopped retiring before the tests finished");
    $display("** FAIL **");
    $fatal(1);
  end

  task automatic applyReset();
    @(posedge clk);
    #1 rst = 1'b1;
    handshakes = 0;
    retires = 0;
    lastNext = RESET_PC;
    repeat (2) @(posedge clk);
    #1 rst = 1'b0;
  endtask

  task automatic clearProgram();
    foreach (prog[i]) prog[i] = 32'h0;  // illegal if ever fetched
    expQ.delete();
  endtask

  task automatic addEntry(input logic [63:0] pc, input logic [31:0] word, input logic rdW,
                          input logic [63:0] rd, input logic [63:0] nxt, input logic mw,
                          input logic [63:0] ma, input logic [63:0] md, input haltCause_t c);
    expect_t e;
    prog[pc[9:2]] = word;
    e = '{pc, word, rdW, rd, nxt, mw, ma, md, c};
    expQ.push_back(e);
  endtask

  task automatic regEntry(input logic [63:0] pc, input logic [31:0] word, input logic [63:0] rd);
    addEntry(pc, word, 1'b1, rd, pc + 64'd4, 1'b0, '0, '0, haltNone);
  endtask

  task automatic branchEntry(input logic [63:0] pc, input logic [31:0] word,
                             input logic [63:0] nxt);
    addEntry(pc, word, 1'b0, '0, nxt, 1'b0, '0, '0, haltNone);
  endtask

  task automatic storeEntry(input logic [63:0] pc, input logic [31:0] word,
                            input logic [63:0] ma, input logic [63:0] md);
    addEntry(pc, word, 1'b0, '0, pc + 64'd4, 1'b1, ma, md, haltNone);
  endtask

  task automatic haltEntry(input logic [63:0] pc, input logic [31:0] word, input haltCause_t c);
    addEntry(pc, word, 1'b0, '0, pc + 64'd4, 1'b0, '0, '0, c);
  endtask

  // reset and check every retire against the queue
  task automatic runProgram();
    expect_t e;
    applyReset();
    foreach (expQ[i]) begin
      e = expQ[i];
      do begin
        @(posedge clk);
        #1;
      end while (!retire.valid);
      checkEq("retire.pc", e.pc, retire.pc);
      checkEq("retire.instr", 64'(e.instr), 64'(retire.instr));
      checkEq("retire.rdWrite", 64'(e.rdWrite), 64'(retire.rdWrite));
      if (e.rdWrite) begin
        checkEq("retire.rdAddr", 64'(e.instr[11:7]), 64'(retire.rdAddr));
        checkEq("retire.rdData", e.rdData, retire.rdData);
      end
      checkEq("retire.nextPc", e.nextPc, retire.nextPc);
      checkEq("retire.memWrite", 64'(e.memWrite), 64'(retire.memWrite));
      if (e.memWrite) begin
        checkEq("retire.memAddr", e.memAddr, retire.memAddr);
        checkEq("retire.memData", e.memData, retire.memData);
      end
      checkEq("haltCause", 64'(e.cause), 64'(haltCause));
      checkEq("halted", 64'(e.cause != haltNone), 64'(halted));
    end
  endtask

  task automatic arithmeticOps();
    clearProgram();
    regEntry(0,  encI(opcOpImm, 1, 0, 0, -5),     64'hFFFF_FFFF_FFFF_FFFB);
    regEntry(4,  encI(opcOpImm, 2, 0, 0, 3),      64'd3);
    regEntry(8,  encI(opcOpImm, 3, 2, 1, 0),      64'd1);   // slti
    regEntry(12, encI(opcOpImm, 4, 3, 2, 5),      64'd1);   // sltiu
    regEntry(16, encI(opcOpImm, 5, 4, 1, -1),     64'd4);   // xori not
    regEntry(20, encI(opcOpImm, 6, 6, 2, 'h70),   64'h73);
    regEntry(24, encI(opcOpImm, 7, 7, 1, 'h0F),   64'hB);
    regEntry(28, encI(opcOpImm, 8, 1, 2, 40),     64'h300_0000_0000);
    regEntry(32, encI(opcOpImm, 9, 5, 1, 60),     64'hF);
    regEntry(36, encI(opcOpImm, 10, 5, 1, 'h401), 64'hFFFF_FFFF_FFFF_FFFD);  // srai
    regEntry(40, encR(0, 0, 11, 1, 2), 64'hFFFF_FFFF_FFFF_FFFE);
    regEntry(44, encR(0, 'h20, 12, 2, 1), 64'd8);                  // sub
    regEntry(48, encR(1, 0, 13, 2, 2), 64'h18);
    regEntry(52, encR(2, 0, 14, 1, 2), 64'd1);
    regEntry(56, encR(3, 0, 15, 1, 2), 64'd0);
    regEntry(60, encR(4, 0, 16, 1, 2), 64'hFFFF_FFFF_FFFF_FFF8);
    regEntry(64, encR(5, 0, 17, 1, 2), 64'h1FFF_FFFF_FFFF_FFFF);
    regEntry(68, encR(5, 'h20, 18, 1, 2), 64'hFFFF_FFFF_FFFF_FFFF);  // sra
    regEntry(72, encR(6, 0, 19, 1, 2), 64'hFFFF_FFFF_FFFF_FFFB);
    regEntry(76, encR(7, 0, 20, 1, 2), 64'd3);
    regEntry(80, encR(0, 1, 21, 1, 2), 64'hFFFF_FFFF_FFFF_FFF1);     // mul
    haltEntry(84, EBREAK_INSTR, haltEbreak);
    runProgram();
  endtask

  task automatic upperImmAndJumps();
    clearProgram();
    regEntry(0, encU(opcLui, 1, 'h12345), 64'h1234_5000);
    regEntry(4, encU(opcLui, 2, 'h80000), 64'hFFFF_FFFF_8000_0000);
    regEntry(8, encU(opcAuipc, 3, 1), 64'h1008);
    addEntry(12, encJ(4, 12), 1'b1, 64'd16, 64'd24, 1'b0, '0, '0, haltNone);
    regEntry(24, encI(opcOpImm, 6, 0, 0, 45), 64'd45);
    addEntry(28, encI(opcJalr, 5, 0, 6, 0), 1'b1, 64'd32, 64'd44, 1'b0, '0, '0, haltNone);
    regEntry(44, encI(opcOpImm, 0, 0, 0, 7), 64'd7);  // x0 write dropped
    regEntry(48, encR(0, 0, 7, 0, 1), 64'h1234_5000);
    haltEntry(52, EBREAK_INSTR, haltEbreak);
    runProgram();
  endtask

  task automatic branchConditions();
    clearProgram();
    regEntry(0, encI(opcOpImm, 1, 0, 0, -1), 64'hFFFF_FFFF_FFFF_FFFF);
    regEntry(4, encI(opcOpImm, 2, 0, 0, 1), 64'd1);
    branchEntry(8,  encB(0, 2, 2, 8), 64'd16);   // beq taken
    branchEntry(16, encB(0, 1, 2, 8), 64'd20);
    branchEntry(20, encB(1, 1, 2, 8), 64'd28);   // bne taken
    branchEntry(28, encB(1, 2, 2, 8), 64'd32);
    branchEntry(32, encB(4, 1, 2, 8), 64'd40);   // -1 < 1 signed
    branchEntry(40, encB(4, 2, 1, 8), 64'd44);
    branchEntry(44, encB(5, 2, 1, 8), 64'd52);
    branchEntry(52, encB(5, 1, 2, 8), 64'd56);
    branchEntry(56, encB(6, 2, 1, 8), 64'd64);   // 1 < max unsigned
    branchEntry(64, encB(6, 1, 2, 8), 64'd68);
    branchEntry(68, encB(7, 1, 2, 8), 64'd76);
    branchEntry(76, encB(7, 2, 1, -76), 64'd80);
    haltEntry(80, EBREAK_INSTR, haltEbreak);
    runProgram();
  endtask

  task automatic loadsAndStores();
    clearProgram();
    regEntry(0,  encU(opcLui, 1, 'h12345), 64'h1234_5000);
    regEntry(4,  encI(opcOpImm, 1, 0, 1, 'h678), 64'h1234_5678);
    regEntry(8,  encI(opcOpImm, 2, 1, 1, 32), 64'h1234_5678_0000_0000);
    regEntry(12, encR(4, 0, 4, 2, 1), 64'h1234_5678_1234_5678);
    regEntry(16, encI(opcOpImm, 5, 0, 0, -126), 64'hFFFF_FFFF_FFFF_FF82);
    regEntry(20, encI(opcOpImm, 6, 0, 0, 'h100), 64'h100);  // base address
    storeEntry(24, encS(3, 6, 4, 0), 64'h100, 64'h1234_5678_1234_5678);
    storeEntry(28, encS(2, 6, 5, 8), 64'h108, 64'hFFFF_FFFF_FFFF_FF82);
    storeEntry(32, encS(1, 6, 5, 16), 64'h110, 64'hFFFF_FFFF_FFFF_FF82);
    storeEntry(36, encS(0, 6, 5, 24), 64'h118, 64'hFFFF_FFFF_FFFF_FF82);
    regEntry(40, encI(opcLoad, 7, 3, 6, 0), 64'h1234_5678_1234_5678);
    regEntry(44, encI(opcLoad, 8, 2, 6, 8), 64'hFFFF_FFFF_FFFF_FF82);
    regEntry(48, encI(opcLoad, 9, 6, 6, 8), 64'h0000_0000_FFFF_FF82);  // lwu
    regEntry(52, encI(opcLoad, 10, 1, 6, 16), 64'hFFFF_FFFF_FFFF_FF82);
    regEntry(56, encI(opcLoad, 11, 5, 6, 16), 64'hFF82);
    regEntry(60, encI(opcLoad, 12, 0, 6, 24), 64'hFFFF_FFFF_FFFF_FF82);
    regEntry(64, encI(opcLoad, 13, 4, 6, 24), 64'h82);
    regEntry(68, encI(opcLoad, 14, 1, 6, 2), 64'h1234);  // upper half lane
    regEntry(72, encI(opcLoad, 15, 4, 6, 5), 64'h56);
    regEntry(76, encI(opcLoad, 16, 2, 6, 4), 64'h1234_5678);
    haltEntry(80, EBREAK_INSTR, haltEbreak);
    runProgram();
  endtask

  task automatic haltAndIllegal();
    clearProgram();
    regEntry(0, encI(opcOpImm, 1, 0, 0, 1), 64'd1);
    haltEntry(4, EBREAK_INSTR, haltEbreak);
    runProgram();
    repeat (10) begin
      @(posedge clk);
      #1 checkEq("fetchReq", 64'd0, 64'(fetchReq));
    end
    clearProgram();
    haltEntry(0, 32'hFFFF_FFFF, haltIllegal);  // opcode 7f unknown
    runProgram();
  endtask

  initial begin
    rst = 1'b1;
    fetchAck = 1'b0;
    instr = 32'h0;
    clearProgram();
    arithmeticOps();
    upperImmAndJumps();
    branchConditions();
    loadsAndStores();
    haltAndIllegal();
    $display("** PASS **");
    $finish;
  end

endmodule

`default_nettype wire

//--- rvCore.f
+incdir+verification
hdl/rvCorePkg.sv
hdl/rvDecoder.sv
hdl/rvAlu.sv
hdl/rvRegFile.sv
hdl/rvBranchUnit.sv
hdl/rvDataMem.sv
hdl/rvExecCore.sv
verification/rvCoreTb.sv

//--- Makefile
SIM = obj_dir/VrvCoreTb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f rvCore.f --top-module rvCoreTb

run: build
	./$(SIM) | tee sim.log
	@! grep -q '\*\* FAIL \*\*' sim.log
	@grep -q '\*\* PASS \*\*' sim.log

lint:
	verilator --lint-only --timing -f rvCore.f --top-module rvCoreTb

clean:
	rm -rf obj_dir sim.log
